/* sources.f */
design/sccb_pkg.sv
design/sccb_msg_if.sv
design/sccb_tx_framer.sv
design/sccb_rx_deframer.sv
design/wb_req_engine.sv
design/wb_comp_engine.sv
design/sccb_wb_bridge.sv
dv/tb_sccb_wb_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_sccb_wb_bridge

rm -rf obj_dir "$LOG"

if ! verilator --binary --assert -f sources.f --top-module "$TOP" -o sim --Mdir obj_dir; then
	echo "Build failed"
	exit 1
fi

if ! ./obj_dir/sim > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -q "All tests passed!" "$LOG"; then
	exit 0
fi
exit 1

/* dv/tb_sccb_wb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sccb_wb_bridge;

	localparam int LINK_IDLES = 4;
	localparam int N_TRANS = 56;
	localparam int WATCHDOG_CYCLES = N_TRANS * 64 + 400;

	logic			sysclk;
	logic			rst_n;
	logic [31:0]	rx_data;
	logic [3:0]		rx_kflags;
	logic [31:0]	tx_data;
	logic [3:0]		tx_kflags;
	logic			link_up;
	logic			s_cyc, s_stb, s_we;
	logic [24:0]	s_adr;
	logic [31:0]	s_dat_w, s_dat_r;
	logic [3:0]		s_sel;
	logic			s_ack, s_err;
	logic			m_cyc, m_stb, m_we;
	logic [24:0]	m_adr;
	logic [31:0]	m_dat_w, m_dat_r;
	logic [3:0]		m_sel;
	logic			m_ack, m_err;

	// Lane corruption and bookkeeping
	logic			corrupt;
	logic			remote_ok;
	logic			exp_we;
	logic [24:0]	exp_adr;
	logic [31:0]	exp_dat_w;
	logic [3:0]		exp_sel;
	string			test_name;
	int				errors;
	int				n_trans;
	int				stall_left;
	logic [31:0]	stall_seed;
	logic [31:0]	stim_seed;
	logic [31:0]	mem [64];
	logic [31:0]	shadow [64];

	sccb_wb_bridge #(.LINK_IDLES(LINK_IDLES)) dut_i (.*);

	// Loopback with a corrupt control word swapped in on demand
	assign rx_data		= corrupt ? 32'h0000_0055 : tx_data;
	assign rx_kflags	= corrupt ? 4'b0001 : tx_kflags;

	initial sysclk = 1'b0;
	always #4 sysclk = ~sysclk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte lanes with sel set take the new data
	function automatic logic [31:0] byte_merge(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++)
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		return res;
	endfunction

	//////////////////////////////////////////////////
	// Remote memory model with ack delay of 0 to 3 cycles

	always begin
		@(posedge sysclk);
		#1;
		m_ack = 1'b0;
		m_err = 1'b0;
		if (!rst_n) begin
			stall_left = -1;
		end else if (m_cyc && m_stb) begin
			if (stall_left < 0) begin
				stall_seed = lcg_step(stall_seed);
				stall_left = int'(stall_seed[17:16]);
			end
			if (stall_left == 0) begin
				stall_left = -1;
				// Past the 64 words of memory
				if (m_adr >= 25'd64) begin
					m_err = 1'b1;
				end else begin
					m_ack = 1'b1;
					if (m_we)
						mem[m_adr[5:0]] = byte_merge(mem[m_adr[5:0]], m_dat_w, m_sel);
					else
						m_dat_r = mem[m_adr[5:0]];
				end
			end else begin
				stall_left--;
			end
		end
	end

	//////////////////////////////////////////////////
	// Protocol checks

	kflags_legal: assert property (@(posedge sysclk) disable iff (!rst_n)
		(tx_kflags == 4'b0001) || (tx_kflags == 4'b0000))
		else begin
			errors++;
			$display("error %s: tx_kflags expected 0001 or 0000 actual %b",
				test_name, tx_kflags);
		end

	// Control words on the lane are only idle commas or start words
	ctrl_word_legal: assert property (@(posedge sysclk) disable iff (!rst_n)
		(tx_kflags == 4'b0001) |-> ((tx_data == 32'h0000_00bc) || (tx_data == 32'h0000_00fb)))
		else begin
			errors++;
			$display("error %s: control word expected 000000bc or 000000fb actual %h",
				test_name, tx_data);
		end

	ack_err_excl: assert property (@(posedge sysclk) disable iff (!rst_n) !(s_ack && s_err))
		else begin
			errors++;
			$display("s_ack and s_err were high together in %s", test_name);
		end

	end_pulse: assert property (@(posedge sysclk) disable iff (!rst_n)
		(s_ack || s_err) |=> !(s_ack || s_err))
		else begin
			errors++;
			$display("s_ack or s_err stayed high for more than one cycle in %s", test_name);
		end

	// Remote cycles only where a local cycle with link up asked for one
	no_stray_cycle: assert property (@(posedge sysclk) disable iff (!rst_n) m_cyc |-> remote_ok)
		else begin
			errors++;
			$display("m_cyc appeared without a local cycle in %s", test_name);
		end

	// Classic single cycles keep stb together with cyc
	stb_with_cyc: assert property (@(posedge sysclk) disable iff (!rst_n) m_stb == m_cyc)
		else begin
			errors++;
			$display("m_stb and m_cyc did not move together in %s", test_name);
		end

	remote_fields: assert property (@(posedge sysclk) disable iff (!rst_n)
		m_cyc |-> (m_adr == exp_adr) && (m_we == exp_we) && (m_sel == exp_sel) &&
			(!exp_we || (m_dat_w == exp_dat_w)))
		else begin
			errors++;
			$display({"error %s: m_* expected adr %h we %b sel %h dat %h ",
				"actual adr %h we %b sel %h dat %h"},
				test_name, exp_adr, exp_we, exp_sel, exp_dat_w, m_adr, m_we, m_sel, m_dat_w);
		end

	// Link down means an err on the very next cycle
	fail_fast: assert property (@(posedge sysclk) disable iff (!rst_n)
		(s_cyc && s_stb && !link_up && !s_ack && !s_err) |=> s_err)
		else begin
			errors++;
			$display("local cycle with link down did not end in s_err next cycle in %s",
				test_name);
		end

	link_drop: assert property (@(posedge sysclk) disable iff (!rst_n) corrupt |=> !link_up)
		else begin
			errors++;
			$display("link_up stayed high after a corrupt word in %s", test_name);
		end

	//////////////////////////////////////////////////
	// Stimulus tasks

	task automatic wait_link(input int limit);
		int n;
		n = 0;
		while (!link_up && (n < limit + 4)) begin
			@(posedge sysclk);
			#1;
			n++;
		end
		assert (link_up && (n <= limit))
			else begin
				errors++;
				$display("error %s: link_up cycles expected <= %0d actual %0d", test_name, limit, n);
			end
	endtask

	// One classic cycle on the local port followed by one idle cycle
	task automatic bus_cycle(input logic we, input logic [24:0] adr, input logic [31:0] wdata,
			input logic [3:0] sel, output logic got_err, output logic [31:0] got_data);
		exp_we		= we;
		exp_adr		= adr;
		exp_dat_w	= wdata;
		exp_sel		= sel;
		s_cyc		= 1'b1;
		s_stb		= 1'b1;
		s_we		= we;
		s_adr		= adr;
		s_dat_w		= wdata;
		s_sel		= sel;
		do begin
			@(posedge sysclk);
			#1;
		end while (!s_ack && !s_err);
		got_err		= s_err;
		got_data	= s_dat_r;
		s_cyc		= 1'b0;
		s_stb		= 1'b0;
		@(posedge sysclk);
		#1;
	endtask

	task automatic run_access(input logic we, input logic [24:0] adr, input logic [31:0] wdata,
			input logic [3:0] sel);
		logic			got_err;
		logic [31:0]	got_data;
		logic			exp_err;
		logic [31:0]	exp_data;
		exp_err		= (adr >= 25'd64);
		exp_data	= shadow[adr[5:0]];
		remote_ok	= 1'b1;
		bus_cycle(we, adr, wdata, sel, got_err, got_data);
		n_trans++;
		assert (got_err == exp_err)
			else begin
				errors++;
				$display("error %s: s_err expected %b actual %b", test_name, exp_err, got_err);
			end
		if (!exp_err && we) begin
			shadow[adr[5:0]] = byte_merge(shadow[adr[5:0]], wdata, sel);
			assert (mem[adr[5:0]] == shadow[adr[5:0]])
				else begin
					errors++;
					$display("error %s: mem expected %h actual %h", test_name,
						shadow[adr[5:0]], mem[adr[5:0]]);
				end
		end else if (!exp_err) begin
			assert (got_data == exp_data)
				else begin
					errors++;
					$display("error %s: s_dat_r expected %h actual %h",
						test_name, exp_data, got_data);
				end
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic			got_err;
		logic [31:0]	got_data;
		logic [31:0]	r;
		errors		= 0;
		n_trans		= 0;
		test_name	= "reset";
		rst_n		= 1'b0;
		corrupt		= 1'b0;
		remote_ok	= 1'b0;
		{s_cyc, s_stb, s_we, s_adr, s_dat_w, s_sel} = '0;
		{m_dat_r, m_ack, m_err} = '0;
		{exp_we, exp_adr, exp_dat_w, exp_sel} = '0;
		stall_left	= -1;
		stall_seed	= 32'd53848;
		stim_seed	= 32'd53848;
		for (int i = 0; i < 64; i++) begin
			mem[i]		= 32'h5a00_0000 ^ (i * 32'h0001_0203);
			shadow[i]	= mem[i];
		end
		repeat (10) @(posedge sysclk);
		#1;
		rst_n = 1'b1;

		// Training from loopback idles
		test_name = "link_train";
		wait_link(LINK_IDLES + 2);
		repeat (8) @(posedge sysclk);
		#1;

		test_name = "write";
		run_access(1'b1, 25'd5, 32'hdead_beef, 4'hf);
		test_name = "read";
		run_access(1'b0, 25'd5, 32'h0, 4'hf);
		run_access(1'b0, 25'd17, 32'h0, 4'hf);

		test_name = "bad_addr";
		run_access(1'b1, 25'd64, 32'h1234_5678, 4'hf);
		run_access(1'b0, 25'd100, 32'h0, 4'hf);

		// One corrupt word and then a cycle while the link is down
		test_name = "link_down";
		corrupt = 1'b1;
		@(posedge sysclk);
		#1;
		corrupt		= 1'b0;
		remote_ok	= 1'b0;
		bus_cycle(1'b0, 25'd3, 32'h0, 4'hf, got_err, got_data);
		n_trans++;
		assert (got_err)
			else begin
				errors++;
				$display("error %s: s_err expected 1 actual %b", test_name, got_err);
			end
		wait_link(LINK_IDLES + 2);

		// Mixed traffic with a few addresses past the memory
		test_name = "random";
		for (int i = 0; i < 50; i++) begin
			stim_seed	= lcg_step(stim_seed);
			r			= stim_seed;
			stim_seed	= lcg_step(stim_seed);
			run_access(r[16], 25'((r >> 20) % 70), stim_seed, r[11:8]);
		end

		$display("Errors: %0d, transactions: %0d", errors, n_trans);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sysclk);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* design/sccb_wb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module sccb_wb_bridge #(
	parameter int LINK_IDLES = 4
) (
	input wire									sysclk,
	input wire									rst_n,

	// Lane
	input wire sccb_pkg::sccb_word_t			rx_data,
	input wire sccb_pkg::sccb_kflags_t			rx_kflags,
	output wire sccb_pkg::sccb_word_t			tx_data,
	output wire sccb_pkg::sccb_kflags_t			tx_kflags,
	output wire									link_up,

	// Local Wishbone completer
	input wire									s_cyc,
	input wire									s_stb,
	input wire									s_we,
	input wire [sccb_pkg::WB_ADDR_BITS-1:0]		s_adr,
	input wire [31:0]							s_dat_w,
	input wire [3:0]							s_sel,
	output wire [31:0]							s_dat_r,
	output wire									s_ack,
	output wire									s_err,

	// Remote Wishbone requester
	output wire									m_cyc,
	output wire									m_stb,
	output wire									m_we,
	output wire [sccb_pkg::WB_ADDR_BITS-1:0]	m_adr,
	output wire [31:0]							m_dat_w,
	output wire [3:0]							m_sel,
	input wire [31:0]							m_dat_r,
	input wire									m_ack,
	input wire									m_err
);

	//////////////////////////////////////////////////
	// Message paths between bus engines and lane

	sccb_msg_if req_out();
	sccb_msg_if rsp_out();
	sccb_msg_if req_in();
	sccb_msg_if rsp_in();

	//////////////////////////////////////////////////
	// Lane side

	sccb_tx_framer framer_i (
		.sysclk(sysclk),
		.rst_n(rst_n),
		.link_up(link_up),
		.req(req_out),
		.rsp(rsp_out),
		.tx_data(tx_data),
		.tx_kflags(tx_kflags)
	);

	sccb_rx_deframer #(
		.LINK_IDLES(LINK_IDLES)
	) deframer_i (
		.sysclk(sysclk),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_kflags(rx_kflags),
		.link_up(link_up),
		.req(req_in),
		.rsp(rsp_in)
	);

	//////////////////////////////////////////////////
	// Bus side

	wb_req_engine req_eng_i (
		.sysclk(sysclk),
		.rst_n(rst_n),
		.req(req_in),
		.rsp(rsp_out),
		.m_cyc(m_cyc),
		.m_stb(m_stb),
		.m_we(m_we),
		.m_adr(m_adr),
		.m_dat_w(m_dat_w),
		.m_sel(m_sel),
		.m_dat_r(m_dat_r),
		.m_ack(m_ack),
		.m_err(m_err)
	);

	wb_comp_engine comp_eng_i (
		.sysclk(sysclk),
		.rst_n(rst_n),
		.link_up(link_up),
		.s_cyc(s_cyc),
		.s_stb(s_stb),
		.s_we(s_we),
		.s_adr(s_adr),
		.s_dat_w(s_dat_w),
		.s_sel(s_sel),
		.s_dat_r(s_dat_r),
		.s_ack(s_ack),
		.s_err(s_err),
		.req(req_out),
		.rsp(rsp_in)
	);

endmodule

`default_nettype wire

/* design/wb_comp_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_comp_engine (
	input wire									sysclk,
	input wire									rst_n,
	input wire									link_up,

	input wire									s_cyc,
	input wire									s_stb,
	input wire									s_we,
	input wire [sccb_pkg::WB_ADDR_BITS-1:0]		s_adr,
	input wire [31:0]							s_dat_w,
	input wire [3:0]							s_sel,
	output logic [31:0]							s_dat_r,
	output logic								s_ack,
	output logic								s_err,

	sccb_msg_if.src								req,
	sccb_msg_if.dst								rsp
);
	import sccb_pkg::*;

	typedef enum logic [1:0] {
		C_IDLE,
		C_SEND,
		C_WAIT
	} state_t;

	state_t		state;

	// Outgoing request
	logic		req_v;
	sccb_hdr_u	req_hdr;
	sccb_word_t	req_data;

	logic		new_cycle;
	logic		rsp_take;

	//////////////////////////////////////////////////
	// Handshakes

	// A cycle being ended this clock is not a new one
	assign new_cycle	= s_cyc && s_stb && !s_ack && !s_err;

	// Responses are always taken, stale ones are simply dropped
	assign rsp.ready	= 1'b1;
	assign rsp_take		= rsp.valid && rsp.ready;

	assign req.valid	= req_v;
	assign req.hdr		= req_hdr;
	assign req.data		= req_data;

	//////////////////////////////////////////////////
	// Cycle FSM

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			state	<= C_IDLE;
			req_v	<= 1'b0;
			s_ack	<= 1'b0;
			s_err	<= 1'b0;
		end else begin
			s_ack	<= 1'b0;
			s_err	<= 1'b0;
			case (state)
				C_IDLE: begin
					if (new_cycle) begin
						if (link_up) begin
							req_v	<= 1'b1;
							state	<= C_SEND;
						end else begin
							// No link, fail at once
							s_err	<= 1'b1;
						end
					end
				end
				C_SEND: begin
					// Link lost before the framer took it, withdraw
					if (!link_up) begin
						req_v	<= 1'b0;
						s_err	<= 1'b1;
						state	<= C_IDLE;
					end else if (req_v && req.ready) begin
						req_v	<= 1'b0;
						state	<= C_WAIT;
					end
				end
				C_WAIT: begin
					if (rsp_take) begin
						s_ack	<= !rsp.hdr.rsp.error;
						s_err	<= rsp.hdr.rsp.error;
						state	<= C_IDLE;
					end else if (!link_up) begin
						s_err	<= 1'b1;
						state	<= C_IDLE;
					end
				end
				default:
					state	<= C_IDLE;
			endcase
		end
	end

	// Request build and read data return
	always_ff @(posedge sysclk) begin
		if ((state == C_IDLE) && new_cycle) begin
			req_hdr.req	<= '{kind: REQ, write: s_we, sel: s_sel, addr: s_adr};
			req_data	<= s_we ? s_dat_w : '0;
		end
		if ((state == C_WAIT) && rsp_take)
			s_dat_r		<= rsp.data;
	end

endmodule

`default_nettype wire

/* design/wb_req_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_req_engine (
	input wire									sysclk,
	input wire									rst_n,

	sccb_msg_if.dst								req,
	sccb_msg_if.src								rsp,

	output logic								m_cyc,
	output logic								m_stb,
	output logic								m_we,
	output logic [sccb_pkg::WB_ADDR_BITS-1:0]	m_adr,
	output logic [31:0]							m_dat_w,
	output logic [3:0]							m_sel,
	input wire [31:0]							m_dat_r,
	input wire									m_ack,
	input wire									m_err
);
	import sccb_pkg::*;

	// Pending response
	logic		rsp_v;
	sccb_hdr_u	rsp_hdr;
	sccb_word_t	rsp_data;

	logic		req_take;
	logic		wb_done;

	//////////////////////////////////////////////////
	// Handshakes

	// One request at a time, the next waits for the response to leave
	assign req.ready	= !m_cyc && !rsp_v;
	assign req_take		= req.valid && req.ready;

	// Classic cycle ends on either ack or err
	assign wb_done		= m_cyc && (m_ack || m_err);

	assign rsp.valid	= rsp_v;
	assign rsp.hdr		= rsp_hdr;
	assign rsp.data		= rsp_data;

	//////////////////////////////////////////////////
	// Bus cycle control

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			m_cyc	<= 1'b0;
			m_stb	<= 1'b0;
			rsp_v	<= 1'b0;
		end else begin
			if (req_take) begin
				m_cyc	<= 1'b1;
				m_stb	<= 1'b1;
			end else if (wb_done) begin
				m_cyc	<= 1'b0;
				m_stb	<= 1'b0;
				rsp_v	<= 1'b1;
			end
			if (rsp_v && rsp.ready)
				rsp_v	<= 1'b0;
		end
	end

	// Request fields and response packing
	always_ff @(posedge sysclk) begin
		if (req_take) begin
			m_we	<= req.hdr.req.write;
			m_sel	<= req.hdr.req.sel;
			m_adr	<= req.hdr.req.addr;
			m_dat_w	<= req.data;
		end
		if (wb_done) begin
			rsp_hdr.rsp	<= '{kind: RSP, error: m_err, rsvd: '0};
			// Writes and failed reads send back zero
			rsp_data	<= (m_we || m_err) ? '0 : m_dat_r;
		end
	end

endmodule

`default_nettype wire

/* design/sccb_rx_deframer.sv */
`timescale 1ns/1ps
`default_nettype none

module sccb_rx_deframer #(
	parameter int LINK_IDLES = 4
) (
	input wire							sysclk,
	input wire							rst_n,

	input wire sccb_pkg::sccb_word_t	rx_data,
	input wire sccb_pkg::sccb_kflags_t	rx_kflags,

	output logic						link_up,

	sccb_msg_if.src						req,
	sccb_msg_if.src						rsp
);
	import sccb_pkg::*;

	localparam int CNT_W = $clog2(LINK_IDLES + 1);

	// Word expected next on the lane
	typedef enum logic [1:0] {
		S_HUNT,
		S_HDR,
		S_DATA
	} state_t;

	state_t				state;
	logic [CNT_W-1:0]	idle_cnt;

	// Set when the current frame must be thrown away
	logic				drop_q;

	// Held output message
	logic				req_v;
	logic				rsp_v;
	sccb_hdr_u			out_hdr;
	sccb_word_t			out_data;

	sccb_hdr_u			rx_hdr;
	logic				is_idle;
	logic				is_start;
	logic				bad_word;

	//////////////////////////////////////////////////
	// Word classification

	// Incoming word seen through the header union
	assign rx_hdr	= rx_data;

	assign is_idle	= (rx_data == K_IDLE) && (rx_kflags == KF_CTRL);
	assign is_start	= (rx_data == K_START) && (rx_kflags == KF_CTRL);

	always_comb begin
		case (state)
			// Between frames only idles and starts are legal
			S_HUNT:
				bad_word = !is_idle && !is_start;
			// Kind is read before a view is chosen
			S_HDR:
				bad_word = (rx_kflags != KF_DATA) ||
					!((rx_hdr.req.kind == REQ) || (rx_hdr.req.kind == RSP));
			default:
				bad_word = (rx_kflags != KF_DATA);
		endcase
	end

	//////////////////////////////////////////////////
	// Link state and frame tracking

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			state		<= S_HUNT;
			link_up		<= 1'b0;
			idle_cnt	<= '0;
			drop_q		<= 1'b0;
			req_v		<= 1'b0;
			rsp_v		<= 1'b0;
		end else begin
			// Release the held message once taken
			if (req_v && req.ready)
				req_v	<= 1'b0;
			if (rsp_v && rsp.ready)
				rsp_v	<= 1'b0;

			// Link training on consecutive idles
			if (bad_word) begin
				link_up		<= 1'b0;
				idle_cnt	<= '0;
			end else if (is_idle) begin
				if (!link_up) begin
					if (idle_cnt == CNT_W'(LINK_IDLES - 1))
						link_up		<= 1'b1;
					else
						idle_cnt	<= idle_cnt + 1'b1;
				end
			end else begin
				// Any other good word breaks the idle run
				idle_cnt	<= '0;
			end

			case (state)
				S_HUNT: begin
					if (link_up && is_start) begin
						state	<= S_HDR;
						// Still holding a message, so this frame goes nowhere
						drop_q	<= req_v || rsp_v;
					end
				end
				S_HDR: begin
					if (bad_word)
						state	<= S_HUNT;
					else
						state	<= S_DATA;
				end
				S_DATA: begin
					state	<= S_HUNT;
					if (!bad_word && !drop_q) begin
						if (out_hdr.req.kind == REQ)
							req_v	<= 1'b1;
						else
							rsp_v	<= 1'b1;
					end
				end
				default:
					state	<= S_HUNT;
			endcase
		end
	end

	// Header and data capture
	always_ff @(posedge sysclk) begin
		if ((state == S_HDR) && !bad_word && !drop_q)
			out_hdr		<= rx_hdr;
		if ((state == S_DATA) && !bad_word && !drop_q)
			out_data	<= rx_data;
	end

	// Both outputs share one message buffer
	assign req.valid	= req_v;
	assign req.hdr		= out_hdr;
	assign req.data		= out_data;
	assign rsp.valid	= rsp_v;
	assign rsp.hdr		= out_hdr;
	assign rsp.data		= out_data;

endmodule

`default_nettype wire

/* design/sccb_tx_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module sccb_tx_framer (
	input wire							sysclk,
	input wire							rst_n,
	input wire							link_up,

	sccb_msg_if.dst						req,
	sccb_msg_if.dst						rsp,

	output sccb_pkg::sccb_word_t		tx_data,
	output sccb_pkg::sccb_kflags_t		tx_kflags
);
	import sccb_pkg::*;

	//////////////////////////////////////////////////
	// Arbitration

	// Next word to send after the start word
	typedef enum logic [1:0] {
		S_IDLE,
		S_HDR,
		S_DATA
	} state_t;

	state_t		state;

	// Latched copy of the granted message
	sccb_hdr_u	msg_hdr;
	sccb_word_t	msg_data;

	logic		can_take;
	logic		take_rsp;
	logic		take_req;

	// Only take a message between frames with the link up
	assign can_take = link_up && (state == S_IDLE);

	// Responses go first so the remote side is never starved
	assign rsp.ready = can_take;
	assign req.ready = can_take && !rsp.valid;

	assign take_rsp = rsp.valid && rsp.ready;
	assign take_req = req.valid && req.ready;

	//////////////////////////////////////////////////
	// Frame sequencer

	always_ff @(posedge sysclk) begin
		if (!rst_n) begin
			state		<= S_IDLE;
			tx_data		<= K_IDLE;
			tx_kflags	<= KF_CTRL;
		end else begin
			case (state)
				S_IDLE: begin
					tx_kflags	<= KF_CTRL;
					if (take_rsp || take_req) begin
						tx_data	<= K_START;
						state	<= S_HDR;
					end else begin
						// Nothing to send, keep the comma stream going
						tx_data	<= K_IDLE;
					end
				end
				S_HDR: begin
					tx_data		<= msg_hdr;
					tx_kflags	<= KF_DATA;
					state		<= S_DATA;
				end
				S_DATA: begin
					tx_data		<= msg_data;
					tx_kflags	<= KF_DATA;
					state		<= S_IDLE;
				end
				default: begin
					tx_data		<= K_IDLE;
					tx_kflags	<= KF_CTRL;
					state		<= S_IDLE;
				end
			endcase
		end
	end

	// Message latch
	always_ff @(posedge sysclk) begin
		if (take_rsp) begin
			msg_hdr		<= rsp.hdr;
			msg_data	<= rsp.data;
		end else if (take_req) begin
			msg_hdr		<= req.hdr;
			msg_data	<= req.data;
		end
	end

endmodule

`default_nettype wire

/* design/sccb_msg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sccb_msg_if;
	import sccb_pkg::*;

	// Handshake, transfer when both are high
	logic		valid;
	logic		ready;

	// Header and data word of one frame
	sccb_hdr_u	hdr;
	sccb_word_t	data;

	// Source holds valid and fields steady until the transfer
	modport src(
		output valid,
		output hdr,
		output data,
		input ready
	);

	modport dst(
		input valid,
		input hdr,
		input data,
		output ready
	);

endinterface

`default_nettype wire

/* design/sccb_pkg.sv */
`default_nettype none

package sccb_pkg;

	//////////////////////////////////////////////////
	// Lane symbols

	// One lane word, four 8b/10b bytes per clock
	typedef logic [31:0] sccb_word_t;

	// K flag per byte, bit 0 goes with byte 0
	typedef logic [3:0] sccb_kflags_t;

	// Idle comma K28.5 in byte 0
	localparam sccb_word_t K_IDLE = 32'h0000_00bc;

	// Start of frame K27.7 in byte 0
	localparam sccb_word_t K_START = 32'h0000_00fb;

	// Flag patterns for control and data words
	localparam sccb_kflags_t KF_CTRL = 4'b0001;
	localparam sccb_kflags_t KF_DATA = 4'b0000;

	//////////////////////////////////////////////////
	// Frame header

	// Wishbone word address width, fixed by the header layout
	localparam int WB_ADDR_BITS = 25;

	typedef enum logic [1:0] {
		NONE	= 2'd0,
		REQ		= 2'd1,
		RSP		= 2'd2
	} sccb_kind_e;

	// Request view
	typedef struct packed {
		sccb_kind_e					kind;
		logic						write;
		logic [3:0]					sel;
		logic [WB_ADDR_BITS-1:0]	addr;
	} sccb_req_hdr_t;

	// Response view, reserved bits are sent as zero
	typedef struct packed {
		sccb_kind_e		kind;
		logic			error;
		logic [28:0]	rsvd;
	} sccb_rsp_hdr_t;

	// Kind sits in the top two bits of both views
	typedef union packed {
		sccb_req_hdr_t	req;
		sccb_rsp_hdr_t	rsp;
	} sccb_hdr_u;

endpackage

`default_nettype wire
